//--- all.f
common/br_pkg.sv
branch/br_cond_eval.sv
branch/br_target_gen.sv
branch/br_mispredict_check.sv
src/br_issue_ctrl.sv
src/br_unit_top.sv
bench/br_unit_tb.sv

//--- bench/br_unit_tb.sv
// Run from the project root so the vector file path resolves, and every vector must be a branch opcode
`timescale 1ns/1ps

module br_unit_tb;
	import br_pkg::*;

	localparam int    CLK_PERIOD     = 40;
	localparam int    RST_CYCLES     = 3;
	localparam int    CYCLES_PER_VEC = 20;  // Worst case handshake is about ten cycles
	localparam int    WATCHDOG_SLACK = 100; // Reset and file setup
	localparam string VEC_FILE       = "bench/branch_input.txt";

	logic       clk;
	logic       rst;
	logic       req;
	logic       ack;
	br_issue_t  issue;
	br_result_t result;

	int          vec_count  = 0;            // Set once the count line is read
	logic [31:0] lfsr_state = 32'h54b0_30fb;

	br_unit_top DUT (
		.clk      (clk),
		.rst      (rst),
		.req_i    (req),
		.issue_i  (issue),
		.ack_o    (ack),
		.result_o (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Single exit point for every failure
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_result(input string name, input br_result_t exp, input br_result_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s expected taken=%b target=%h br_pc=%h rob=%h mis=%b",
				name, exp.taken, exp.target, exp.br_pc, exp.rob_idx, exp.mispredict);
			$display("Mismatch %s actual   taken=%b target=%h br_pc=%h rob=%h mis=%b",
				name, act.taken, act.target, act.br_pc, act.rob_idx, act.mispredict);
			fail_run("Result packet does not match the expected branch outcome");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Mismatch %s expected %b actual %b", name, exp, act);
			fail_run("Handshake level is wrong");
		end
	endtask

	// Fibonacci LFSR, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// Three fresh bits give 0..7 extra hold cycles
	task automatic draw_hold(output int cycles);
		logic [2:0] bits;
		for (int b = 0; b < 3; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			bits[b]    = lfsr_state[0];
		end
		cycles = int'(bits);
	endtask

	// Skips blank lines and lines starting with #
	task automatic next_data_line(input int fd, output string line, output bit found);
		string raw;
		int    rc;
		found = 1'b0;
		line  = "";
		while (!found && !$feof(fd))
		begin
			rc = $fgets(raw, fd);
			if ((rc > 0) && (raw.len() > 1) && (raw.getc(0) != "#"))
			begin
				line  = raw;
				found = 1'b1;
			end
		end
	endtask

	// One full four-phase handshake, called right after a falling edge
	task automatic run_vector(input string name, input br_issue_t pkt, input br_result_t exp);
		int hold;
		issue = pkt;
		req   = 1'b1;
		@(posedge clk); // Capture edge
		@(negedge clk);
		check_bit({name, " ack one edge after req"}, 1'b0, ack);
		@(posedge clk); // Ack and result edge
		@(negedge clk);
		check_bit({name, " ack two edges after req"}, 1'b1, ack);
		check_result(name, exp, result);
		draw_hold(hold);
		repeat (hold)
		begin
			@(posedge clk);
			@(negedge clk);
			check_bit({name, " ack during hold"}, 1'b1, ack);
			check_result({name, " during hold"}, exp, result); // Must not move
		end
		req = 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " ack after req drop"}, 1'b0, ack);
	endtask

	initial
	begin
		int          fd;
		int          fields;
		bit          found;
		string       line;
		br_issue_t   pkt;
		br_result_t  exp;
		logic [31:0] f_inst;
		logic [63:0] f_npc;
		logic [63:0] f_opa;
		logic [63:0] f_opb;
		logic        f_pt;
		logic [63:0] f_ptgt;
		logic [4:0]  f_rob;
		logic        f_et;
		logic [63:0] f_etgt;
		logic        f_em;

		rst   = 1'b1;
		req   = 1'b0;
		issue = '0;

		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
			fail_run("Cannot open the stimulus file bench/branch_input.txt");
		next_data_line(fd, line, found);
		if (!found || ($sscanf(line, "%d", vec_count) != 1) || (vec_count <= 0))
			fail_run("Stimulus file has no usable vector count");

		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_bit("reset ack", 1'b0, ack);
		check_result("reset result", '0, result);

		for (int v = 0; v < vec_count; v++)
		begin
			next_data_line(fd, line, found);
			if (!found)
				fail_run("Stimulus file ends before the vector count is reached");
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
				f_inst, f_npc, f_opa, f_opb, f_pt, f_ptgt, f_rob, f_et, f_etgt, f_em);
			if (fields != 10)
				fail_run("Stimulus line does not hold ten hex fields");

			pkt.inst        = f_inst;
			pkt.npc         = f_npc;
			pkt.opa         = f_opa;
			pkt.opb         = f_opb;
			pkt.pred_taken  = f_pt;
			pkt.pred_target = f_ptgt;
			pkt.rob_idx     = f_rob;

			exp.taken      = f_et;
			exp.target     = f_etgt;
			exp.br_pc      = f_npc;  // Echo of the next PC
			exp.rob_idx    = f_rob;
			exp.mispredict = f_em;

			run_vector($sformatf("vector %0d", v), pkt, exp);
		end
		$fclose(fd);

		$display("*** TEST PASSED ***");
		$finish;
	end

	// Bounded run even if ack never moves
	initial
	begin
		wait (vec_count > 0);
		repeat (vec_count * CYCLES_PER_VEC + WATCHDOG_SLACK) @(posedge clk);
		fail_run("Handshake hung, watchdog expired before all vectors finished");
	end

endmodule

//--- bench/branch_input.txt
# Columns: inst npc opa opb pred_taken pred_target rob_idx exp_taken exp_target exp_mispredict
# All vector fields are hex, the first data line is the vector count in decimal
23
E0200010 1000 2A 0 1 1040 01 1 1040 0
E0200010 1000 2B 0 1 1040 02 0 1000 1
E43FFFF0 1000 0 0 1 FC0 03 1 FC0 0
E43FFFF0 1000 1 0 0 DEAD 04 0 1000 0
E8200010 1000 FFFFFFFFFFFFFFF0 0 1 1080 05 1 1040 1
E8200010 1000 0 0 0 0 06 0 1000 0
EC200010 1000 0 0 0 0 07 1 1040 1
EC200010 1000 2B 0 0 0 08 0 1000 0
EC3FFFF0 1000 FFFFFFFFFFFFFFF0 0 1 FC0 09 1 FC0 0
F0200010 1000 1 0 1 1040 0A 1 1040 0
F0200010 1000 2A 0 0 0 0B 0 1000 0
F43FFFF0 1000 2B 0 1 FC0 0C 1 FC0 0
F43FFFF0 1000 0 0 1 FC0 0D 0 1000 1
F8200010 1000 0 0 1 1040 0E 1 1040 0
F8200010 1000 FFFFFFFFFFFFFFF0 0 0 0 0F 0 1000 0
FC200010 1000 2A 0 1 1040 10 1 1040 0
FC200010 1000 0 0 0 0 11 0 1000 0
C3EFFFFF 20000 0 0 1 41FFFC 12 1 41FFFC 0
D3500000 800000 0 0 0 0 13 1 400000 1
6BE20000 3000 0 12345677 1 12345674 14 1 12345674 0
6B424000 3000 0 FFFFFFFF80000003 1 0 15 1 FFFFFFFF80000000 1
6BFA8001 3000 0 7FF0 0 0 16 1 7FF0 1
6BFAC000 3000 0 4002 1 4000 1F 1 4000 0

//--- branch/br_cond_eval.sv
// Pure combinational and only meaningful for opcodes 0x38 to 0x3F since func bits are not qualified
`timescale 1ns/1ps

module br_cond_eval (
	input  logic [br_pkg::FUNC_W-1:0] func_i,      // Opcode bits 2:0
	input  logic [br_pkg::ADDR_W-1:0] opa_i,       // Ra value
	output logic                      cond_true_o
);
	import br_pkg::*;

	logic base_cond; // Test before the invert bit
	logic opa_zero;
	logic opa_neg;

	assign opa_zero = (opa_i == '0);
	assign opa_neg  = opa_i[ADDR_W-1]; // Sign bit of the 64-bit word

	always_comb
	begin
		case (func_i[1:0])
			2'b00:   base_cond = ~opa_i[0];            // BLBC
			2'b01:   base_cond = opa_zero;             // BEQ
			2'b10:   base_cond = opa_neg;              // BLT
			default: base_cond = opa_neg | opa_zero;   // BLE
		endcase
	end

	// Bit 2 flips to BLBS, BNE, BGE, BGT
	assign cond_true_o = base_cond ^ func_i[2];

endmodule

//--- branch/br_mispredict_check.sv
// Target compare only counts on taken branches and a not-taken prediction target is ignored
`timescale 1ns/1ps

module br_mispredict_check (
	input  br_pkg::br_issue_t         issue_i,
	input  br_pkg::br_class_e         class_i,
	input  logic                      cond_true_i,
	input  logic [br_pkg::ADDR_W-1:0] target_i,
	output br_pkg::br_result_t        result_o
);
	import br_pkg::*;

	logic taken;
	logic dir_wrong;  // Direction disagrees with predictor
	logic tgt_wrong;  // Taken but to somewhere else

	always_comb
	begin
		case (class_i)
			BRC_UNCOND, BRC_JUMP: taken = 1'b1;
			BRC_COND:             taken = cond_true_i;
			default:              taken = 1'b0; // Non-branch never redirects
		endcase
	end

	assign dir_wrong = (taken != issue_i.pred_taken);
	assign tgt_wrong = taken && (target_i != issue_i.pred_target);

	assign result_o.taken      = taken;
	assign result_o.target     = taken ? target_i : issue_i.npc;
	assign result_o.br_pc      = issue_i.npc;     // Reported as the next PC
	assign result_o.rob_idx    = issue_i.rob_idx;
	assign result_o.mispredict = dir_wrong | tgt_wrong;

endmodule

//--- branch/br_target_gen.sv
// Jump targets come straight from opb so an R31 Rb must already read as zero at issue
`timescale 1ns/1ps

module br_target_gen (
	input  br_pkg::br_issue_t         issue_i,
	output br_pkg::br_class_e         class_o,
	output logic [br_pkg::ADDR_W-1:0] target_o
);
	import br_pkg::*;

	logic [OP_W-1:0]   br_op;      // Opcode seen through the branch format
	logic [OP_W-1:0]   jmp_op;     // Same bits through the jump format
	logic [ADDR_W-1:0] disp_ext;   // Sign-extended byte displacement
	logic [ADDR_W-1:0] pcrel_tgt;
	logic [ADDR_W-1:0] jump_tgt;

	assign br_op  = issue_i.inst.br_fmt.opcode;
	assign jmp_op = issue_i.inst.jmp_fmt.opcode;

	// Longword displacement scaled to bytes
	assign disp_ext = {
		{(ADDR_W - DISP_W - ALIGN_W){issue_i.inst.br_fmt.disp[DISP_W-1]}},
		issue_i.inst.br_fmt.disp,
		{ALIGN_W{1'b0}}
	};

	assign pcrel_tgt = issue_i.npc + disp_ext; // Relative to the updated PC

	// Low bits dropped to keep the fetch aligned
	assign jump_tgt = {issue_i.opb[ADDR_W-1:ALIGN_W], {ALIGN_W{1'b0}}};

	always_comb
	begin
		// Fall through unless a branch kind matches
		class_o  = BRC_NONE;
		target_o = issue_i.npc;

		if (jmp_op == OP_JMP)
		begin
			// All four jkind flavours share one target rule
			class_o  = BRC_JUMP;
			target_o = jump_tgt;
		end
		else if ((br_op == OP_BR) || (br_op == OP_BSR))
		begin
			class_o  = BRC_UNCOND;
			target_o = pcrel_tgt;
		end
		else if (br_op[OP_W-1 -: COND_TOP_W] == OP_COND_TOP)
		begin
			// Target formed regardless of direction
			class_o  = BRC_COND;
			target_o = pcrel_tgt;
		end
	end

endmodule

//--- common/br_pkg.sv
// Widths are fixed for a 64-bit Alpha datapath and FP branches or PAL calls have no branch class
package br_pkg;

	// Word and field widths
	localparam int ADDR_W    = 64; // PC and register value
	localparam int INST_W    = 32; // Instruction word
	localparam int ROB_IDX_W = 5;  // 32-entry reorder buffer
	localparam int OP_W      = 6;  // Major opcode
	localparam int REG_W     = 5;  // Register specifier
	localparam int JKIND_W   = 2;  // JMP/JSR/RET/JSR_CO select
	localparam int FUNC_W    = 3;  // Condition function bits in the opcode
	localparam int ALIGN_W   = 2;  // Instructions are longword aligned

	// Derived from the instruction word so both formats fill 32 bits
	localparam int DISP_W = INST_W - OP_W - REG_W;                      // 21
	localparam int HINT_W = INST_W - OP_W - (2 * REG_W) - JKIND_W;      // 14

	// Branch opcodes
	localparam logic [OP_W-1:0] OP_BR  = 6'h30; // Unconditional
	localparam logic [OP_W-1:0] OP_BSR = 6'h34; // Unconditional with link
	localparam logic [OP_W-1:0] OP_JMP = 6'h1A; // Memory-format jumps

	// Integer conditional branches live at 0x38..0x3F
	localparam int COND_TOP_W = OP_W - FUNC_W;
	localparam logic [COND_TOP_W-1:0] OP_COND_TOP = 3'b111;

	// Branch format: opcode, Ra, 21-bit longword displacement
	typedef struct packed {
		logic [OP_W-1:0]   opcode;
		logic [REG_W-1:0]  ra;
		logic [DISP_W-1:0] disp;
	} br_fmt_t;

	// Jump format: target comes from Rb
	typedef struct packed {
		logic [OP_W-1:0]    opcode;
		logic [REG_W-1:0]   ra;
		logic [REG_W-1:0]   rb;
		logic [JKIND_W-1:0] jkind;  // Only a hint for the return stack
		logic [HINT_W-1:0]  hint;   // Prediction hint, ignored here
	} jmp_fmt_t;

	// Same word, two decodes
	typedef union packed {
		br_fmt_t  br_fmt;
		jmp_fmt_t jmp_fmt;
	} br_inst_t;

	// Branch kind after decode
	typedef enum logic [1:0] {
		BRC_UNCOND, // BR, BSR
		BRC_COND,   // BLBC..BGT
		BRC_JUMP,   // JMP, JSR, RET, JSR_CO
		BRC_NONE    // Not a branch
	} br_class_e;

	// Packet from the issue stage
	typedef struct packed {
		br_inst_t             inst;
		logic [ADDR_W-1:0]    npc;         // PC of the branch plus 4
		logic [ADDR_W-1:0]    opa;         // Ra value
		logic [ADDR_W-1:0]    opb;         // Rb value
		logic                 pred_taken;
		logic [ADDR_W-1:0]    pred_target;
		logic [ROB_IDX_W-1:0] rob_idx;
	} br_issue_t;

	// Resolved branch back to the issuer
	typedef struct packed {
		logic                 taken;
		logic [ADDR_W-1:0]    target;      // Fall-through npc when not taken
		logic [ADDR_W-1:0]    br_pc;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic                 mispredict;
	} br_result_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds with Verilator, runs from the project root and greps the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module br_unit_tb -o br_unit_sim \
	&& ./obj_dir/br_unit_sim | tee sim.log \
	|| echo "Build or simulation ended with an error"
grep -qF "*** TEST PASSED ***" sim.log \
	&& echo "Simulation result: pass" \
	|| { echo "Simulation result: fail"; exit 1; }

//--- src/br_issue_ctrl.sv
// One branch in flight and the issuer must hold req_i and issue_i stable until ack_o is seen high
`timescale 1ns/1ps

module br_issue_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_i,
	input  br_pkg::br_issue_t  issue_i,
	input  br_pkg::br_result_t next_result_i,  // From the combinational datapath
	input  br_pkg::br_class_e  class_i,
	output logic               ack_o,
	output br_pkg::br_issue_t  cur_issue_o,    // Captured packet feeding the datapath
	output br_pkg::br_result_t result_o
);
	import br_pkg::*;

	typedef enum logic [1:0] {
		IDLE, // Waiting for req
		EVAL, // Datapath settling on the captured packet
		HOLD  // Ack high until req drops
	} state_e;

	state_e state;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= IDLE;
			ack_o    <= 1'b0;
			result_o <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (req_i)
						state <= EVAL; // Packet latched below on this edge
				end
				EVAL:
				begin
					result_o <= next_result_i;
					ack_o    <= 1'b1;      // Result valid with ack
					state    <= HOLD;
				end
				HOLD:
				begin
					// Back-pressure holds ack and result
					if (!req_i)
					begin
						ack_o <= 1'b0;
						state <= IDLE;
					end
				end
				default:
				begin
					ack_o <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

	// Payload register loaded on the accepting edge only
	always_ff @(posedge clk)
	begin
		if ((state == IDLE) && req_i)
			cur_issue_o <= issue_i;
	end

	// Ack only answers a live request on the edge where it rises
	a_ack_needs_req: assert property (
		@(posedge clk) disable iff (rst)
		$rose(ack_o) |-> $past(req_i)
	) else $error("ack_o rose without req_i");

	// Issuer must never send a non-branch
	a_class_valid: assert property (
		@(posedge clk) disable iff (rst)
		(state == EVAL) |-> (class_i != BRC_NONE)
	) else $error("Non-branch opcode reached the branch unit");

endmodule

//--- src/br_unit_top.sv
// Four-phase req/ack only with no pipelining so throughput is one branch per full handshake
`timescale 1ns/1ps

module br_unit_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_i,
	input  br_pkg::br_issue_t  issue_i,
	output logic               ack_o,
	output br_pkg::br_result_t result_o
);
	import br_pkg::*;

	br_issue_t         cur_issue;     // Captured packet
	logic              cond_true;
	br_class_e         br_class;
	logic [ADDR_W-1:0] actual_target;
	br_result_t        next_result;   // Registered by the controller

	br_issue_ctrl u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.req_i         (req_i),
		.issue_i       (issue_i),
		.next_result_i (next_result),
		.class_i       (br_class),
		.ack_o         (ack_o),
		.cur_issue_o   (cur_issue),
		.result_o      (result_o)
	);

	// Function bits are the low opcode bits
	br_cond_eval u_cond (
		.func_i      (cur_issue.inst.br_fmt.opcode[FUNC_W-1:0]),
		.opa_i       (cur_issue.opa),
		.cond_true_o (cond_true)
	);

	br_target_gen u_tgt (
		.issue_i  (cur_issue),
		.class_o  (br_class),
		.target_o (actual_target)
	);

	br_mispredict_check u_chk (
		.issue_i     (cur_issue),
		.class_i     (br_class),
		.cond_true_i (cond_true),
		.target_i    (actual_target),
		.result_o    (next_result)
	);

endmodule
